//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := eppHostTb
FILELIST  := verilog.f
OBJDIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

# Pass is decided by the pass line in the simulation output
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST PASS$$'

clean:
	rm -rf $(OBJDIR)

//--- capture/captureUnit.sv
`timescale 1ns/1ps
`default_nettype none

module captureUnit (
  input  logic        clkMain,
  input  logic        reset_in,
  input  logic        sampleStrobe,
  input  logic        capArm,
  input  logic        ctrlWrStb,
  input  logic        capPopStb,
  input  logic [15:0] sampleData,
  input  logic [15:0] matchValue,
  input  logic [15:0] matchMask,
  output logic [7:0]  capStatus,
  output logic [7:0]  capLow,
  output logic [7:0]  capHigh
);
  import eppPkg::*;

  logic [15:0]                  fifoMem [CAP_DEPTH];
  logic [$clog2(CAP_DEPTH)-1:0] wrPtr;
  logic [$clog2(CAP_DEPTH)-1:0] rdPtr;
  logic [$clog2(CAP_DEPTH):0]   count;
  logic                         overflow;
  logic                         hit;
  logic                         full;
  logic                         empty;
  logic                         pushOk;
  logic                         popOk;

  // ----------------------------------------------------------------------
  // Masked comparator
  // ----------------------------------------------------------------------
  // Mask bits at 0 are don't care
  assign hit = capArm && sampleStrobe &&
               ((sampleData & matchMask) == (matchValue & matchMask));

  // Depth is a power of two, so the count MSB means full
  assign full   = count[$clog2(CAP_DEPTH)];
  assign empty  = (count == '0);
  // A hit on a full FIFO is dropped
  assign pushOk = hit && !full;
  assign popOk  = capPopStb && !empty;

  // ----------------------------------------------------------------------
  // FIFO
  // ----------------------------------------------------------------------
  always_ff @(posedge clkMain) begin
    if (pushOk) begin
      fifoMem[wrPtr] <= sampleData;
    end
  end

  always_ff @(posedge clkMain) begin
    if (reset_in) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (pushOk) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (popOk) begin
        rdPtr <= rdPtr + 1'b1;
      end
      // Push and pop together leave the count alone
      case ({pushOk, popOk})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
      // Sticky flag that a new drop sets even in a clearing cycle
      if (hit && full) begin
        overflow <= 1'b1;
      end else if (ctrlWrStb) begin
        overflow <= 1'b0;
      end
    end
  end

  // Overflow in bit 7 and the count in the low bits
  assign capStatus = {overflow, 4'b0000, count};
  // Head reads as zero while empty
  assign capLow    = empty ? 8'h00 : fifoMem[rdPtr][7:0];
  assign capHigh   = empty ? 8'h00 : fifoMem[rdPtr][15:8];

  aCountBound: assert property (@(posedge clkMain) disable iff (reset_in)
    count <= CAP_DEPTH);

endmodule

`default_nettype wire

//--- common/eppPkg.sv
`default_nettype none

package eppPkg;

  // ----------------------------------------------------------------------
  // Widths
  // ----------------------------------------------------------------------
  // EPP register address, low nibble of the address byte
  localparam int ADDR_WIDTH = 4;
  // SRAM word address, byte select comes from pointer bit 0
  localparam int RAM_WORD_WIDTH = 15;
  // Capture FIFO entries
  localparam int CAP_DEPTH = 4;

  // ----------------------------------------------------------------------
  // Register map
  // ----------------------------------------------------------------------
  // SRAM data port, pointer auto-increments
  localparam logic [3:0] REG_RAM_DATA = 4'd0;
  // Byte pointer, bit 0 of the low byte selects the lane
  localparam logic [3:0] REG_PTR_LOW  = 4'd1;
  localparam logic [3:0] REG_PTR_HIGH = 4'd2;
  // Match value and mask for the capture comparator
  localparam logic [3:0] REG_MATCH_LO = 4'd3;
  localparam logic [3:0] REG_MATCH_HI = 4'd4;
  localparam logic [3:0] REG_MASK_LO  = 4'd5;
  localparam logic [3:0] REG_MASK_HI  = 4'd6;
  // Bit 0 arms capture, any write clears overflow
  localparam logic [3:0] REG_CTRL     = 4'd7;
  // Capture status, FIFO head bytes; reading the high byte pops
  localparam logic [3:0] REG_CAP_STAT = 4'd8;
  localparam logic [3:0] REG_CAP_LO   = 4'd9;
  localparam logic [3:0] REG_CAP_HI   = 4'd10;
  // Addresses above this one read the switches

  // EPP cycle states, A/B/C sequence per cycle type
  typedef enum logic [3:0] {
    ready,
    addrWrA, addrWrB, addrWrC,
    addrRdA, addrRdB, addrRdC,
    dataWrA, dataWrB, dataWrC,
    dataRdA, dataRdB, dataRdC
  } eppState;

endpackage

`default_nettype wire

//--- dv/eppHostTb.sv
`timescale 1ns/1ps
`default_nettype none

module eppHostTb;
  import eppPkg::*;

  localparam int N_ADDR    = 12;
  localparam int N_REG     = 16;
  localparam int N_RAM     = 20;
  localparam int N_ROUNDS  = 2;
  localparam int N_SAMPLES = 10;
  localparam int N_SW      = 8;
  // EPP cycles over all tests with pops counted at full depth
  localparam int EPP_CYCLES = 22 + 2 * N_ADDR + 4 * N_REG + 10 + 4 * N_RAM + 20
                              + 40 * N_ROUNDS + 2 * N_SW;
  localparam int CYCLE_LIMIT = EPP_CYCLES * 16 + 2 * N_SAMPLES * N_ROUNDS + 200;

  logic        clkMain;
  logic        reset_in;
  logic        astb;
  logic        dstb;
  logic        pwr;
  logic [7:0]  hostData;
  logic        hostOe;
  logic [7:0]  pdbBus;
  logic        pwait;
  logic [7:0]  pdbOut;
  logic        pdbOe;
  logic [7:0]  switches;
  logic [7:0]  led;
  logic        sampleStrobe;
  logic [15:0] sampleData;
  logic [14:0] ramAddr;
  logic [15:0] ramWrData;
  logic [15:0] ramRdData;
  logic        ramWe;
  logic        ramOe;
  logic        ramLbN;
  logic        ramUbN;

  // Reference model state
  logic [7:0]  regMap [16];
  logic [15:0] mPtr;
  logic [7:0]  mRam [65536];
  logic [15:0] capQ [$];
  logic        mOvf;
  int          checkCount;
  int          errorCount;
  int          contentionCount;
  int          cycleCount;

  // Bus resolution with the idle bus floating high
  assign pdbBus = pdbOe ? pdbOut : (hostOe ? hostData : 8'hff);

  eppHost u_dut (
    .clkMain(clkMain), .reset_in(reset_in), .astb(astb), .dstb(dstb), .pwr(pwr),
    .pdbIn(pdbBus), .pwait(pwait), .pdbOut(pdbOut), .pdbOe(pdbOe),
    .switches(switches), .led(led), .sampleStrobe(sampleStrobe), .sampleData(sampleData),
    .ramAddr(ramAddr), .ramWrData(ramWrData), .ramRdData(ramRdData),
    .ramWe(ramWe), .ramOe(ramOe), .ramLbN(ramLbN), .ramUbN(ramUbN)
  );

  sramModel u_sram (
    .clkMain(clkMain), .addr(ramAddr), .wrData(ramWrData), .rdData(ramRdData),
    .weN(ramWe), .oeN(ramOe), .lbN(ramLbN), .ubN(ramUbN)
  );

  always #4 clkMain = ~clkMain;

  // Run limit
  always @(posedge clkMain) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CYCLE_LIMIT) begin
      $display("TEST FAIL");
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $finish;
    end
  end

  // Host and DUT must never drive the bus together
  always @(posedge clkMain) begin
    if (hostOe && pdbOe) begin
      contentionCount <= contentionCount + 1;
      $display("Bus contention at %0t ns: host and DUT both drive the data bus", $time);
    end
  end

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  // Expected read value including the side effects of the read
  function automatic logic [7:0] expectRead(input logic [3:0] a);
    logic [7:0] v;
    v = 8'h00;
    case (a)
      REG_RAM_DATA: begin
        v = mRam[mPtr];
        mPtr = mPtr + 16'd1;
      end
      REG_PTR_LOW:  v = mPtr[7:0];
      REG_PTR_HIGH: v = mPtr[15:8];
      REG_CAP_STAT: v = {mOvf, 4'b0000, 3'(capQ.size())};
      REG_CAP_LO: begin
        if (capQ.size() > 0) begin
          v = capQ[0][7:0];
        end
      end
      REG_CAP_HI: begin
        if (capQ.size() > 0) begin
          v = capQ[0][15:8];
          void'(capQ.pop_front());
        end
      end
      default: v = (a > REG_CAP_HI) ? switches : regMap[a];
    endcase
    return v;
  endfunction

  function automatic void applyWrite(input logic [3:0] a, input logic [7:0] v);
    if (a == REG_RAM_DATA) begin
      mRam[mPtr] = v;
      mPtr = mPtr + 16'd1;
    end else if (a == REG_PTR_LOW) begin
      mPtr[7:0] = v;
    end else if (a == REG_PTR_HIGH) begin
      mPtr[15:8] = v;
    end else if (a >= REG_MATCH_LO && a <= REG_CTRL) begin
      regMap[a] = v;
    end
    // Control write clears the overflow flag
    if (a == REG_CTRL) begin
      mOvf = 1'b0;
    end
  endfunction

  function automatic void applySample(input logic [15:0] s);
    logic [15:0] match;
    logic [15:0] mask;
    match = {regMap[REG_MATCH_HI], regMap[REG_MATCH_LO]};
    mask  = {regMap[REG_MASK_HI], regMap[REG_MASK_LO]};
    if (regMap[REG_CTRL][0] && ((s & mask) == (match & mask))) begin
      if (capQ.size() < CAP_DEPTH) begin
        capQ.push_back(s);
      end else begin
        mOvf = 1'b1;
      end
    end
  endfunction

  // ----------------------------------------------------------------------
  // EPP host side
  // ----------------------------------------------------------------------
  task automatic checkByte(input string what, input logic [7:0] got, input logic [7:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("** Error at %0t ns: %s returned %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  // One strobe cycle with pwr held until pwait falls
  task automatic eppCycle(input logic isAddr, input logic isRead, input logic [7:0] wrVal,
                          output logic [7:0] rdVal);
    @(negedge clkMain);
    pwr      = isRead;
    hostData = wrVal;
    hostOe   = !isRead;
    if (isAddr) begin
      astb = 1'b0;
    end else begin
      dstb = 1'b0;
    end
    do @(negedge clkMain); while (pwait !== 1'b1);
    rdVal = pdbBus;
    if (isRead && pdbOe !== 1'b1) begin
      errorCount++;
      $display("Read cycle at %0t ns: the DUT is not driving the data bus", $time);
    end
    astb = 1'b1;
    dstb = 1'b1;
    do @(negedge clkMain); while (pwait !== 1'b0);
    hostOe = 1'b0;
  endtask

  task automatic eppAddrWr(input logic [7:0] v);
    logic [7:0] ignored;
    eppCycle(1'b1, 1'b0, v, ignored);
  endtask

  task automatic eppAddrRd(output logic [7:0] v);
    eppCycle(1'b1, 1'b1, 8'h00, v);
  endtask

  task automatic eppDataWr(input logic [7:0] v);
    logic [7:0] ignored;
    eppCycle(1'b0, 1'b0, v, ignored);
  endtask

  task automatic eppDataRd(output logic [7:0] v);
    eppCycle(1'b0, 1'b1, 8'h00, v);
  endtask

  task automatic regWrite(input logic [3:0] a, input logic [7:0] v);
    eppAddrWr({4'h0, a});
    eppDataWr(v);
    applyWrite(a, v);
  endtask

  task automatic regCheck(input logic [3:0] a);
    logic [7:0] exp;
    logic [7:0] got;
    exp = expectRead(a);
    eppAddrWr({4'h0, a});
    eppDataRd(got);
    checkByte($sformatf("read of address %0d", a), got, exp);
  endtask

  task automatic reportTest(input int num, input string name, input int errStart);
    $display("Test %0d %s: %s", num, name, (errorCount == errStart) ? "passed" : "failed");
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  initial begin
    logic [7:0]  v;
    logic [7:0]  got;
    logic [3:0]  a;
    logic [15:0] start;
    logic [15:0] addr16;
    logic [15:0] word;
    logic [15:0] sample;
    logic [15:0] match;
    logic [15:0] mask;
    int          errStart;
    int          n;
    clkMain = 1'b0;
    reset_in = 1'b1;
    astb = 1'b1;
    dstb = 1'b1;
    pwr = 1'b0;
    hostData = 8'h00;
    hostOe = 1'b0;
    switches = 8'h00;
    sampleStrobe = 1'b0;
    sampleData = 16'h0000;
    checkCount = 0;
    errorCount = 0;
    contentionCount = 0;
    cycleCount = 0;
    mPtr = 16'h0000;
    mOvf = 1'b0;
    for (int i = 0; i < 16; i++) begin
      regMap[i] = 8'h00;
    end
    void'($urandom(32'hb721_2d59));
    repeat (10) @(posedge clkMain);
    @(negedge clkMain);
    reset_in = 1'b0;
    // Model SRAM starts from the fill pattern
    for (int b = 0; b < 65536; b++) begin
      word = u_sram.mem[15'(b >> 1)];
      mRam[b] = b[0] ? word[15:8] : word[7:0];
    end

    // Reset values
    errStart = errorCount;
    @(negedge clkMain);
    checkByte("led", led, 8'h00);
    checkByte("pwait", {7'b0, pwait}, 8'h00);
    checkByte("pdbOe", {7'b0, pdbOe}, 8'h00);
    checkByte("ramWe", {7'b0, ramWe}, 8'h01);
    checkByte("ramOe", {7'b0, ramOe}, 8'h01);
    for (int i = 0; i <= 10; i++) begin
      regCheck(4'(i));
    end
    reportTest(1, "reset values", errStart);

    // Address register and writable registers
    errStart = errorCount;
    for (int i = 0; i < N_ADDR; i++) begin
      v = 8'($urandom);
      eppAddrWr(v);
      eppAddrRd(got);
      checkByte("address read", got, {4'h0, v[3:0]});
    end
    for (int i = 0; i < N_REG; i++) begin
      a = 4'(3 + $urandom % 5);
      regWrite(a, 8'($urandom));
      regCheck(a);
    end
    for (int i = 3; i <= 7; i++) begin
      regCheck(4'(i));
    end
    checkByte("led", led, regMap[REG_CTRL]);
    reportTest(2, "address and register access", errStart);

    // SRAM writes and reads through the auto-increment pointer
    errStart = errorCount;
    start = 16'($urandom);
    regWrite(REG_PTR_LOW, start[7:0]);
    regWrite(REG_PTR_HIGH, start[15:8]);
    for (int i = 0; i < N_RAM; i++) begin
      @(negedge clkMain);
      checkByte("low lane enable", {7'b0, ramLbN}, {7'b0, mPtr[0]});
      checkByte("high lane enable", {7'b0, ramUbN}, {7'b0, ~mPtr[0]});
      regWrite(REG_RAM_DATA, 8'($urandom));
    end
    regCheck(REG_PTR_LOW);
    regCheck(REG_PTR_HIGH);
    // Neighbors on both ends must be untouched
    for (int b = -1; b <= N_RAM; b++) begin
      addr16 = start + 16'(b);
      word = u_sram.mem[addr16[15:1]];
      checkByte("SRAM byte", addr16[0] ? word[15:8] : word[7:0], mRam[addr16]);
    end
    regWrite(REG_PTR_LOW, start[7:0]);
    regWrite(REG_PTR_HIGH, start[15:8]);
    for (int i = 0; i < N_RAM; i++) begin
      regCheck(REG_RAM_DATA);
    end
    regCheck(REG_PTR_LOW);
    regCheck(REG_PTR_HIGH);
    reportTest(3, "SRAM access", errStart);

    // Capture FIFO with a first round that mostly matches and overflows
    errStart = errorCount;
    for (int r = 0; r < N_ROUNDS; r++) begin
      regWrite(REG_MATCH_LO, 8'($urandom));
      regWrite(REG_MATCH_HI, 8'($urandom));
      regWrite(REG_MASK_LO, 8'($urandom));
      regWrite(REG_MASK_HI, 8'($urandom));
      regWrite(REG_CTRL, 8'h01);
      match = {regMap[REG_MATCH_HI], regMap[REG_MATCH_LO]};
      mask  = {regMap[REG_MASK_HI], regMap[REG_MASK_LO]};
      for (int s = 0; s < N_SAMPLES; s++) begin
        @(negedge clkMain);
        sample = 16'($urandom);
        if (($urandom % 4) < ((r == 0) ? 3 : 1)) begin
          sample = (match & mask) | (sample & ~mask);
        end
        sampleData = sample;
        sampleStrobe = 1'b1;
        applySample(sample);
        @(negedge clkMain);
        sampleStrobe = 1'b0;
      end
      regCheck(REG_CAP_STAT);
      n = capQ.size();
      repeat (n) begin
        regCheck(REG_CAP_LO);
        regCheck(REG_CAP_HI);
      end
      regCheck(REG_CAP_STAT);
      regWrite(REG_CTRL, 8'h01);
      regCheck(REG_CAP_STAT);
    end
    reportTest(4, "capture FIFO", errStart);

    // Switch reads on all aliased addresses
    errStart = errorCount;
    for (int i = 0; i < N_SW; i++) begin
      @(negedge clkMain);
      switches = 8'($urandom);
      regCheck(4'(11 + $urandom % 5));
    end
    reportTest(5, "switches", errStart);

    $display("Summary: %0d checks, %0d errors, %0d contention cycles",
             checkCount, errorCount, contentionCount);
    if (errorCount == 0 && contentionCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/sramModel.sv
`timescale 1ns/1ps
`default_nettype none

module sramModel (
  input  logic        clkMain,
  input  logic [14:0] addr,
  input  logic [15:0] wrData,
  output logic [15:0] rdData,
  input  logic        weN,
  input  logic        oeN,
  input  logic        lbN,
  input  logic        ubN
);

  logic [15:0] mem [32768];

  // Fill pattern, both bytes depend on the word address
  initial begin
    for (int w = 0; w < 32768; w++) begin
      mem[15'(w)] = {{1'b1, 7'(w >> 8)} ^ 8'h3c, 8'(w) ^ 8'h96};
    end
  end

  // Write sampled on the clock so address and lanes are seen before they step
  always @(posedge clkMain) begin
    if (!weN) begin
      if (!lbN) begin
        mem[addr][7:0] <= wrData[7:0];
      end
      if (!ubN) begin
        mem[addr][15:8] <= wrData[15:8];
      end
    end
  end

  // Disabled lanes read as zero
  assign rdData = oeN ? 16'h0000 :
                  {ubN ? 8'h00 : mem[addr][15:8], lbN ? 8'h00 : mem[addr][7:0]};

endmodule

`default_nettype wire

//--- src/eppCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module eppCtrl (
  input  logic                          clkMain,
  input  logic                          reset_in,
  input  logic                          astb,
  input  logic                          dstb,
  input  logic                          pwr,
  input  logic [7:0]                    pdbIn,
  input  logic [7:0]                    readData,
  output logic                          pwait,
  output logic                          pdbOe,
  output logic [7:0]                    pdbOut,
  output logic [eppPkg::ADDR_WIDTH-1:0] eppAddr,
  output logic                          ramWrStb,
  output logic                          ramRdStb,
  output logic                          ramOeWin,
  output logic                          ptrWrLow,
  output logic                          ptrWrHigh,
  output logic                          regWrStb,
  output logic                          capPopStb
);
  import eppPkg::*;

  eppState state;
  eppState stateNext;
  logic    addrRead;
  logic    dataRead;
  logic    addrIsRam;

  // ----------------------------------------------------------------------
  // Cycle FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clkMain) begin
    if (reset_in) begin
      state <= ready;
    end else begin
      state <= stateNext;
    end
  end

  // Address strobe wins if both strobes fall together
  always_comb begin
    stateNext = state;
    case (state)
      ready: begin
        if (!astb) begin
          stateNext = pwr ? addrRdA : addrWrA;
        end else if (!dstb) begin
          stateNext = pwr ? dataRdA : dataWrA;
        end
      end
      addrWrA: stateNext = addrWrB;
      addrWrB: stateNext = addrWrC;
      addrRdA: stateNext = addrRdB;
      addrRdB: stateNext = addrRdC;
      dataWrA: stateNext = dataWrB;
      dataWrB: stateNext = dataWrC;
      dataRdA: stateNext = dataRdB;
      dataRdB: stateNext = dataRdC;
      // Hold C until the host releases its strobe
      addrWrC, addrRdC: begin
        if (astb) begin
          stateNext = ready;
        end
      end
      dataWrC, dataRdC: begin
        if (dstb) begin
          stateNext = ready;
        end
      end
      default: stateNext = ready;
    endcase
  end

  // Address register loads mid-cycle while pdbIn is stable
  always_ff @(posedge clkMain) begin
    if (reset_in) begin
      eppAddr <= '0;
    end else if (state == addrWrB) begin
      eppAddr <= pdbIn[ADDR_WIDTH-1:0];
    end
  end

  // ----------------------------------------------------------------------
  // Handshake and bus drive
  // ----------------------------------------------------------------------
  assign addrRead = state inside {addrRdA, addrRdB, addrRdC};
  assign dataRead = state inside {dataRdA, dataRdB, dataRdC};
  assign pwait    = state inside {addrWrC, addrRdC, dataWrC, dataRdC};
  assign pdbOe    = addrRead || dataRead;
  assign pdbOut   = addrRead ? {{(8 - ADDR_WIDTH){1'b0}}, eppAddr} : readData;

  // ----------------------------------------------------------------------
  // Target strobes from one address decode for all datapath blocks
  // ----------------------------------------------------------------------
  assign addrIsRam = (eppAddr == REG_RAM_DATA);
  assign ramWrStb  = (state == dataWrB) && addrIsRam;
  assign ptrWrLow  = (state == dataWrB) && (eppAddr == REG_PTR_LOW);
  assign ptrWrHigh = (state == dataWrB) && (eppAddr == REG_PTR_HIGH);
  assign regWrStb  = (state == dataWrB) && (eppAddr >= REG_MATCH_LO) && (eppAddr <= REG_CTRL);
  // SRAM output window opens one cycle before the latch edge
  assign ramOeWin  = ((state == dataRdA) || (state == dataRdB)) && addrIsRam;
  assign ramRdStb  = (state == dataRdB) && addrIsRam;
  // Pop on the edge leaving C so the host saw the old head byte
  assign capPopStb = (state == dataRdC) && dstb && (eppAddr == REG_CAP_HI);

  // Write strobes only inside a host write cycle
  aWrInWrite: assert property (@(posedge clkMain) disable iff (reset_in)
    (ramWrStb || ptrWrLow || ptrWrHigh || regWrStb) |-> !pwr);

  // Bus is driven only while the host holds the cycle as a read
  aOeInRead: assert property (@(posedge clkMain) disable iff (reset_in)
    pdbOe |-> pwr);

endmodule

`default_nettype wire

//--- src/eppHost.sv
`timescale 1ns/1ps
`default_nettype none

module eppHost (
  input  logic                              clkMain,
  input  logic                              reset_in,
  // EPP pins, data bus split into in, out and enable
  input  logic                              astb,
  input  logic                              dstb,
  input  logic                              pwr,
  input  logic [7:0]                        pdbIn,
  output logic                              pwait,
  output logic [7:0]                        pdbOut,
  output logic                              pdbOe,
  // Board I/O
  input  logic [7:0]                        switches,
  output logic [7:0]                        led,
  input  logic                              sampleStrobe,
  input  logic [15:0]                       sampleData,
  // SRAM pins
  output logic [eppPkg::RAM_WORD_WIDTH-1:0] ramAddr,
  output logic [15:0]                       ramWrData,
  input  logic [15:0]                       ramRdData,
  output logic                              ramWe,
  output logic                              ramOe,
  output logic                              ramLbN,
  output logic                              ramUbN
);
  import eppPkg::*;

  // ----------------------------------------------------------------------
  // Internal nets
  // ----------------------------------------------------------------------
  logic [ADDR_WIDTH-1:0] eppAddr;
  logic [7:0]            readData;
  logic                  ramWrStb;
  logic                  ramRdStb;
  logic                  ramOeWin;
  logic                  ptrWrLow;
  logic                  ptrWrHigh;
  logic                  regWrStb;
  logic                  capPopStb;
  logic                  ctrlWrStb;
  logic                  capArm;
  logic [7:0]            ramReadByte;
  logic [7:0]            ptrLow;
  logic [7:0]            ptrHigh;
  logic [7:0]            capStatus;
  logic [7:0]            capLow;
  logic [7:0]            capHigh;
  logic [15:0]           matchValue;
  logic [15:0]           matchMask;

  // EPP cycle control and strobe decode
  eppCtrl uCtrl (
    .clkMain   (clkMain),
    .reset_in  (reset_in),
    .astb      (astb),
    .dstb      (dstb),
    .pwr       (pwr),
    .pdbIn     (pdbIn),
    .readData  (readData),
    .pwait     (pwait),
    .pdbOe     (pdbOe),
    .pdbOut    (pdbOut),
    .eppAddr   (eppAddr),
    .ramWrStb  (ramWrStb),
    .ramRdStb  (ramRdStb),
    .ramOeWin  (ramOeWin),
    .ptrWrLow  (ptrWrLow),
    .ptrWrHigh (ptrWrHigh),
    .regWrStb  (regWrStb),
    .capPopStb (capPopStb)
  );

  // Registers and read-back mux
  eppRegs uRegs (
    .clkMain     (clkMain),
    .reset_in    (reset_in),
    .regWrStb    (regWrStb),
    .eppAddr     (eppAddr),
    .pdbIn       (pdbIn),
    .ramReadByte (ramReadByte),
    .ptrLow      (ptrLow),
    .ptrHigh     (ptrHigh),
    .capStatus   (capStatus),
    .capLow      (capLow),
    .capHigh     (capHigh),
    .switches    (switches),
    .readData    (readData),
    .led         (led),
    .matchValue  (matchValue),
    .matchMask   (matchMask),
    .capArm      (capArm),
    .ctrlWrStb   (ctrlWrStb)
  );

  // SRAM pointer and pins
  ramPort uRam (
    .clkMain     (clkMain),
    .reset_in    (reset_in),
    .ramWrStb    (ramWrStb),
    .ramRdStb    (ramRdStb),
    .ramOeWin    (ramOeWin),
    .ptrWrLow    (ptrWrLow),
    .ptrWrHigh   (ptrWrHigh),
    .pdbIn       (pdbIn),
    .ramRdData   (ramRdData),
    .ramAddr     (ramAddr),
    .ramWrData   (ramWrData),
    .ramWe       (ramWe),
    .ramOe       (ramOe),
    .ramLbN      (ramLbN),
    .ramUbN      (ramUbN),
    .ptrLow      (ptrLow),
    .ptrHigh     (ptrHigh),
    .ramReadByte (ramReadByte)
  );

  // Sample matcher and FIFO
  captureUnit uCapture (
    .clkMain      (clkMain),
    .reset_in     (reset_in),
    .sampleStrobe (sampleStrobe),
    .capArm       (capArm),
    .ctrlWrStb    (ctrlWrStb),
    .capPopStb    (capPopStb),
    .sampleData   (sampleData),
    .matchValue   (matchValue),
    .matchMask    (matchMask),
    .capStatus    (capStatus),
    .capLow       (capLow),
    .capHigh      (capHigh)
  );

endmodule

`default_nettype wire

//--- src/eppRegs.sv
`timescale 1ns/1ps
`default_nettype none

module eppRegs (
  input  logic                          clkMain,
  input  logic                          reset_in,
  input  logic                          regWrStb,
  input  logic [eppPkg::ADDR_WIDTH-1:0] eppAddr,
  input  logic [7:0]                    pdbIn,
  input  logic [7:0]                    ramReadByte,
  input  logic [7:0]                    ptrLow,
  input  logic [7:0]                    ptrHigh,
  input  logic [7:0]                    capStatus,
  input  logic [7:0]                    capLow,
  input  logic [7:0]                    capHigh,
  input  logic [7:0]                    switches,
  output logic [7:0]                    readData,
  output logic [7:0]                    led,
  output logic [15:0]                   matchValue,
  output logic [15:0]                   matchMask,
  output logic                          capArm,
  output logic                          ctrlWrStb
);
  import eppPkg::*;

  logic [7:0] matchLo;
  logic [7:0] matchHi;
  logic [7:0] maskLo;
  logic [7:0] maskHi;
  logic [7:0] ctrlReg;

  // ----------------------------------------------------------------------
  // Writable registers
  // ----------------------------------------------------------------------
  // regWrStb only fires for addresses 3 to 7
  always_ff @(posedge clkMain) begin
    if (reset_in) begin
      matchLo <= '0;
      matchHi <= '0;
      maskLo  <= '0;
      maskHi  <= '0;
      ctrlReg <= '0;
    end else if (regWrStb) begin
      case (eppAddr)
        REG_MATCH_LO: matchLo <= pdbIn;
        REG_MATCH_HI: matchHi <= pdbIn;
        REG_MASK_LO:  maskLo  <= pdbIn;
        REG_MASK_HI:  maskHi  <= pdbIn;
        REG_CTRL:     ctrlReg <= pdbIn;
        default: ;
      endcase
    end
  end

  assign matchValue = {matchHi, matchLo};
  assign matchMask  = {maskHi, maskLo};
  assign capArm     = ctrlReg[0];
  assign led        = ctrlReg;
  // Any control write clears the capture overflow flag
  assign ctrlWrStb  = regWrStb && (eppAddr == REG_CTRL);

  // ----------------------------------------------------------------------
  // Read-back mux
  // ----------------------------------------------------------------------
  always_comb begin
    case (eppAddr)
      REG_RAM_DATA: readData = ramReadByte;
      REG_PTR_LOW:  readData = ptrLow;
      REG_PTR_HIGH: readData = ptrHigh;
      REG_MATCH_LO: readData = matchLo;
      REG_MATCH_HI: readData = matchHi;
      REG_MASK_LO:  readData = maskLo;
      REG_MASK_HI:  readData = maskHi;
      REG_CTRL:     readData = ctrlReg;
      REG_CAP_STAT: readData = capStatus;
      REG_CAP_LO:   readData = capLow;
      REG_CAP_HI:   readData = capHigh;
      // Upper addresses all alias the switches
      default:      readData = switches;
    endcase
  end

endmodule

`default_nettype wire

//--- src/ramPort.sv
`timescale 1ns/1ps
`default_nettype none

module ramPort (
  input  logic                              clkMain,
  input  logic                              reset_in,
  input  logic                              ramWrStb,
  input  logic                              ramRdStb,
  input  logic                              ramOeWin,
  input  logic                              ptrWrLow,
  input  logic                              ptrWrHigh,
  input  logic [7:0]                        pdbIn,
  input  logic [15:0]                       ramRdData,
  output logic [eppPkg::RAM_WORD_WIDTH-1:0] ramAddr,
  output logic [15:0]                       ramWrData,
  output logic                              ramWe,
  output logic                              ramOe,
  output logic                              ramLbN,
  output logic                              ramUbN,
  output logic [7:0]                        ptrLow,
  output logic [7:0]                        ptrHigh,
  output logic [7:0]                        ramReadByte
);
  import eppPkg::*;

  // Byte pointer, bit 0 is the lane select
  logic [15:0] ptr;

  // ----------------------------------------------------------------------
  // Pointer
  // ----------------------------------------------------------------------
  // Direct byte loads, otherwise step after each data access
  always_ff @(posedge clkMain) begin
    if (reset_in) begin
      ptr <= '0;
    end else if (ptrWrLow) begin
      ptr[7:0] <= pdbIn;
    end else if (ptrWrHigh) begin
      ptr[15:8] <= pdbIn;
    end else if (ramWrStb || ramRdStb) begin
      ptr <= ptr + 16'd1;
    end
  end

  assign ptrLow  = ptr[7:0];
  assign ptrHigh = ptr[15:8];

  // ----------------------------------------------------------------------
  // SRAM pins
  // ----------------------------------------------------------------------
  assign ramAddr   = ptr[RAM_WORD_WIDTH:1];
  // Same byte on both halves, lane enables pick the target
  assign ramWrData = {pdbIn, pdbIn};
  assign ramWe     = ~ramWrStb;
  assign ramOe     = ~ramOeWin;
  assign ramLbN    = ptr[0];
  assign ramUbN    = ~ptr[0];

  // Read latch, captured on the same edge the pointer steps
  always_ff @(posedge clkMain) begin
    if (ramRdStb) begin
      ramReadByte <= ptr[0] ? ramRdData[15:8] : ramRdData[7:0];
    end
  end

  // Read latch edge falls inside the output enable window
  aRdInOe: assert property (@(posedge clkMain) disable iff (reset_in)
    ramRdStb |-> !ramOe);

  // Never write and drive the SRAM outputs together
  aWeOeExcl: assert property (@(posedge clkMain) disable iff (reset_in)
    ramWe || ramOe);

endmodule

`default_nettype wire

//--- verilog.f
common/eppPkg.sv
src/eppCtrl.sv
src/eppRegs.sv
src/ramPort.sv
capture/captureUnit.sv
src/eppHost.sv
dv/sramModel.sv
dv/eppHostTb.sv
